//--- project.f
+incdir+include
source/video_pkg.sv
source/raster_timing.sv
source/color_ctrl_reg.sv
source/obj_palette_ram.sv
source/video_output_stage.sv
source/psychic5_video_top.sv
testbench/video_timing_checker.sv
testbench/tb_psychic5_video.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_psychic5_video -f project.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "all tests passed" sim.log && ! grep -q "tests failed" sim.log \
    && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

//--- testbench/tb_psychic5_video.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module tb_psychic5_video;

    localparam int FRAME_STEPS = 384 * 264;
    // Two cycles per step; frame test, one frame of window waits, short tests
    localparam int LIMIT = 2 * (2 * FRAME_STEPS + 4000);
    localparam video_pkg::raster_cnt_t H_FIRST = `VID_H_FIRST;
    localparam video_pkg::raster_cnt_t H_LAST  = `VID_H_LAST;
    localparam video_pkg::raster_cnt_t V_FIRST = `VID_V_FIRST;
    localparam video_pkg::raster_cnt_t V_LAST  = `VID_V_LAST;

    logic                 mclk = 1'b0;
    logic                 rst_n;
    logic                 cen12_n;
    logic                 pal_cs_n;
    logic                 ctrl_cs_n;
    video_pkg::cpu_bus_t  cpu;
    video_pkg::pen_t      pixel;
    logic                 pcen_n;
    logic                 ncen_n;
    logic                 csync;
    video_pkg::raster_t   raster;
    video_pkg::rgb_t      video;
    video_pkg::cpu_byte_t rdata;

    // Reference state, advanced once per pixel step
    video_pkg::raster_t   m_ras;
    logic                 m_sync;
    video_pkg::cpu_byte_t m_ctrl;
    video_pkg::pen_t      m_pen;
    logic [1:0]           m_vis;            // Qualifier pipe, [1] is oldest
    video_pkg::rgb_t      m_rd;
    video_pkg::rgb_t      m_video;
    video_pkg::cpu_byte_t pal_img [512];    // Bytes written by the CPU side
    logic                 step_due;         // Next rising edge is a step
    video_pkg::pen_t      s_pix;            // Inputs seen just before the step
    video_pkg::cpu_bus_t  s_cpu;
    logic                 s_pcs_n;
    logic                 s_ccs_n;
    logic                 chk_ras = 1'b0;
    logic                 chk_vid = 1'b0;
    int                   errors = 0;
    int                   err_mark = 0;
    int                   tests_run = 0;
    int                   tests_bad = 0;
    int                   cycles = 0;
    int unsigned          seed = 58207;

    psychic5_video_top UUT (.i_EMU_MCLK(mclk), .i_rst_n(rst_n), .i_EMU_CLK12MPCEN_n(cen12_n),
        .i_obj_palette_cs_n(pal_cs_n), .i_color_ctrl_cs_n(ctrl_cs_n), .i_cpu(cpu),
        .i_obj_pixel(pixel), .o_EMU_CLK6MPCEN_n(pcen_n), .o_EMU_CLK6MNCEN_n(ncen_n),
        .o_csync(csync), .o_raster(raster), .o_video(video), .o_data_read(rdata));

    always #20 mclk = ~mclk;                // 40 ns

    ///////////////////////////////
    // Reference and helpers
    ///////////////////////////////

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Counts one step on; window decoded from the counts before the step
    function automatic video_pkg::raster_t ref_next_raster(input video_pkg::raster_t cur);
        video_pkg::raster_t nx;
        nx.pix_cen = 1'b0;                  // Off on the cycle after a step
        nx.disp_en = (cur.hcnt >= `VID_HDISP_FIRST) &&
                     (cur.vcnt >= `VID_VDISP_FIRST) && (cur.vcnt <= `VID_VDISP_LAST);
        nx.hcnt    = (cur.hcnt == H_LAST) ? H_FIRST : cur.hcnt + 9'd1;
        nx.vcnt    = cur.vcnt;
        if (cur.hcnt == H_LAST)
            nx.vcnt = (cur.vcnt == V_LAST) ? V_FIRST : cur.vcnt + 9'd1;
        return nx;
    endfunction

    function automatic logic ref_sync_n(input video_pkg::raster_t cur);
        return !(((cur.hcnt >= `VID_HSYNC_FIRST) && (cur.hcnt <= `VID_HSYNC_LAST)) ||
                 ((cur.vcnt >= `VID_VSYNC_FIRST) && (cur.vcnt <= `VID_VSYNC_LAST)));
    endfunction

    function automatic video_pkg::rgb_t pal_color(input video_pkg::pen_t e);
        video_pkg::rgb_t c;
        c.r = pal_img[{e, 1'b0}][7:4];      // Even byte R:G
        c.g = pal_img[{e, 1'b0}][3:0];
        c.b = pal_img[{e, 1'b1}][7:4];      // Odd byte B
        return c;
    endfunction

    task automatic check_raster(input string name, input video_pkg::raster_t got,
                                input video_pkg::raster_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got 0x%05h expected 0x%05h", name, got, exp);
        end
    endtask

    task automatic check_rgb(input string name, input video_pkg::rgb_t got,
                             input video_pkg::rgb_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got 0x%03h expected 0x%03h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input video_pkg::cpu_byte_t got,
                              input video_pkg::cpu_byte_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic after_edge();
        @(posedge mclk);
        #1;
    endtask

    // Returns just after the next step edge
    task automatic wait_step();
        @(negedge mclk);
        while (!raster.pix_cen)
            @(negedge mclk);
        after_edge();
    endtask

    task automatic run_pixels(input int n, input logic opaque);
        repeat (n)
        begin
            seed  = lcg_next(seed);
            pixel = opaque ? {seed[23:20], 1'b0, seed[18:16]} : seed[23:16];
            wait_step();
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_mark)
            tests_bad++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        err_mark = errors;
    endtask

    ///////////////////////////////
    // Compare process
    ///////////////////////////////

    // Old values feed new ones, latest stage first
    always @(negedge mclk)
    begin
        if (step_due)
        begin
            m_video = (m_vis[1] && m_ctrl[0]) ? m_rd : '0;
            m_rd    = pal_color(s_pcs_n ? m_pen : s_cpu.addr[8:1]);   // CPU wins
            m_vis   = {m_vis[0], m_ras.disp_en && (s_pix[3:0] != `VID_TRANSPARENT_PEN)};
            m_pen   = s_pix;
            m_sync  = ref_sync_n(m_ras);
            m_ras   = ref_next_raster(m_ras);
            if (!s_ccs_n && !s_cpu.wr_n)
                m_ctrl = s_cpu.wdata;
            if (chk_ras)
            begin
                check_raster("o_raster", raster, m_ras);
                check_bit("o_csync", csync, m_sync);
            end
            if (chk_vid)
                check_rgb("o_video", video, m_video);
        end
        if (chk_ras)
        begin
            check_bit("o_EMU_CLK6MPCEN_n", pcen_n, step_due);   // Step every second cycle
            check_bit("o_EMU_CLK6MNCEN_n", ncen_n, ~step_due);
        end
        step_due = raster.pix_cen;
        s_pix    = pixel;
        s_cpu    = cpu;
        s_pcs_n  = pal_cs_n;
        s_ccs_n  = ctrl_cs_n;
    end

    always @(posedge mclk)
    begin
        cycles++;
        if (cycles > LIMIT)
        begin
            $display("TIMEOUT: no end of run after %0d cycles", LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    ///////////////////////////////
    // Stimulus
    ///////////////////////////////

    initial
    begin : stim
        logic                 prev;
        video_pkg::cpu_addr_t addr;
        rst_n     = 1'b0;
        cen12_n   = 1'b0;                   // 12M enable on every cycle
        pal_cs_n  = 1'b1;
        ctrl_cs_n = 1'b1;
        cpu       = '{addr: '0, wdata: '0, rd_n: 1'b1, wr_n: 1'b1};
        pixel     = '0;
        m_ras     = '{hcnt: H_FIRST, vcnt: V_FIRST, pix_cen: 1'b0, disp_en: 1'b0};
        m_sync    = 1'b1;
        m_ctrl    = `VID_CTRL_RESET;
        m_pen     = '0;
        m_vis     = '0;
        m_rd      = '0;
        m_video   = '0;
        step_due  = 1'b0;
        repeat (8) @(posedge mclk);
        #1 rst_n = 1'b1;

        // Reset state and enable alternation
        @(negedge mclk);
        check_raster("o_raster", raster, m_ras);
        check_bit("o_csync", csync, 1'b1);
        check_rgb("o_video", video, '0);
        @(negedge mclk);
        prev = pcen_n;
        repeat (4)
        begin
            @(negedge mclk);
            check_bit("o_EMU_CLK6MPCEN_n", pcen_n, ~prev);
            check_bit("o_EMU_CLK6MNCEN_n", ncen_n, prev);
            prev = pcen_n;
        end
        end_test("reset");

        // Full frame of raster
        after_edge();
        chk_ras = 1'b1;
        repeat (FRAME_STEPS) wait_step();
        end_test("frame");

        // Fill whole palette, then random read-back
        for (int a = 0; a < 512; a++)
        begin
            seed          = lcg_next(seed);
            addr          = video_pkg::cpu_addr_t'(a);
            pal_img[addr] = seed[23:16];
            pal_cs_n      = 1'b0;
            cpu.addr      = addr;
            cpu.wdata     = seed[23:16];
            cpu.wr_n      = 1'b0;
            wait_step();
        end
        cpu.wr_n = 1'b1;
        repeat (32)
        begin
            seed     = lcg_next(seed);
            addr     = seed[24:16];
            cpu.addr = addr;
            cpu.rd_n = 1'b0;
            wait_step();
            @(negedge mclk);
            check_byte("o_data_read", rdata, pal_img[addr]);
            after_edge();
        end
        cpu.rd_n = 1'b1;                    // Still selected, no read strobe
        @(negedge mclk);
        check_byte("o_data_read idle", rdata, `VID_READ_IDLE);
        after_edge();
        pal_cs_n = 1'b1;
        end_test("palette");

        // Pens through the pipeline, in and out of the window
        repeat (4) wait_step();             // Flush CPU lookups
        while (!raster.disp_en) wait_step();
        chk_vid = 1'b1;
        run_pixels(1000, 1'b0);
        end_test("pixels");

        // Force black and release
        ctrl_cs_n = 1'b0;
        cpu.wdata = 8'h5A;
        cpu.wr_n  = 1'b0;
        wait_step();
        cpu.wr_n  = 1'b1;
        cpu.rd_n  = 1'b0;
        @(negedge mclk);
        check_byte("color ctrl read", rdata, 8'h5A);
        after_edge();
        cpu.rd_n  = 1'b1;
        ctrl_cs_n = 1'b1;
        while (!raster.disp_en) wait_step();
        run_pixels(300, 1'b1);
        ctrl_cs_n = 1'b0;
        cpu.wdata = 8'h01;
        cpu.wr_n  = 1'b0;
        wait_step();
        cpu.wr_n  = 1'b1;
        ctrl_cs_n = 1'b1;
        run_pixels(300, 1'b1);
        @(negedge mclk);
        end_test("force black");

        $display("summary: %0d run, %0d with errors, %0d check errors",
                 tests_run, tests_bad, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- testbench/video_timing_checker.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module video_timing_checker
(
    input  logic                i_EMU_MCLK,
    input  logic                i_rst_n,
    input  logic                i_pcen_n,
    input  logic                i_ncen_n,
    input  video_pkg::raster_t  i_raster
);

    // Counters stay inside their wrap ranges
    a_hcnt_range: assert property (@(posedge i_EMU_MCLK) disable iff (!i_rst_n)
        (i_raster.hcnt >= `VID_H_FIRST) && (i_raster.hcnt <= `VID_H_LAST))
        else $error("hcnt out of range: %0d", i_raster.hcnt);
    a_vcnt_range: assert property (@(posedge i_EMU_MCLK) disable iff (!i_rst_n)
        (i_raster.vcnt >= `VID_V_FIRST) && (i_raster.vcnt <= `VID_V_LAST))
        else $error("vcnt out of range: %0d", i_raster.vcnt);

    // Step and half-step are exclusive
    a_cen_excl: assert property (@(posedge i_EMU_MCLK) i_pcen_n || i_ncen_n)
        else $error("both 6M enables low");

    // Idle enables in reset
    a_cen_reset: assert property (@(posedge i_EMU_MCLK) !i_rst_n |-> (i_pcen_n && i_ncen_n))
        else $error("6M enable active during reset");

endmodule

bind raster_timing video_timing_checker u_timing_chk
(
    .i_EMU_MCLK (i_EMU_MCLK),
    .i_rst_n    (i_rst_n),
    .i_pcen_n   (o_EMU_CLK6MPCEN_n),
    .i_ncen_n   (o_EMU_CLK6MNCEN_n),
    .i_raster   (o_raster)
);

//--- source/psychic5_video_top.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module psychic5_video_top
(
    input  logic                   i_EMU_MCLK,
    input  logic                   i_rst_n,
    input  logic                   i_EMU_CLK12MPCEN_n,
    input  logic                   i_obj_palette_cs_n,
    input  logic                   i_color_ctrl_cs_n,
    input  video_pkg::cpu_bus_t    i_cpu,
    input  video_pkg::pen_t        i_obj_pixel,
    output logic                   o_EMU_CLK6MPCEN_n,
    output logic                   o_EMU_CLK6MNCEN_n,
    output logic                   o_csync,
    output video_pkg::raster_t     o_raster,
    output video_pkg::rgb_t        o_video,
    output video_pkg::cpu_byte_t   o_data_read
);

    logic                 force_black;
    video_pkg::cpu_byte_t ctrl_rdata;
    video_pkg::cpu_byte_t pal_rdata;
    video_pkg::pen_t      pal_pen;
    video_pkg::rgb_t      pal_rgb;

    //////////////////////////////
    // Blocks
    //////////////////////////////

    raster_timing u_raster (.i_EMU_MCLK(i_EMU_MCLK), .i_rst_n(i_rst_n),
        .i_EMU_CLK12MPCEN_n(i_EMU_CLK12MPCEN_n), .o_EMU_CLK6MPCEN_n(o_EMU_CLK6MPCEN_n),
        .o_EMU_CLK6MNCEN_n(o_EMU_CLK6MNCEN_n), .o_csync(o_csync), .o_raster(o_raster));

    color_ctrl_reg u_ctrl (.i_EMU_MCLK(i_EMU_MCLK), .i_rst_n(i_rst_n),
        .i_cs_n(i_color_ctrl_cs_n), .i_cpu(i_cpu), .i_pix_cen(o_raster.pix_cen),
        .o_force_black(force_black), .o_rdata(ctrl_rdata));

    obj_palette_ram u_palette (.i_EMU_MCLK(i_EMU_MCLK), .i_cs_n(i_obj_palette_cs_n),
        .i_cpu(i_cpu), .i_pix_cen(o_raster.pix_cen), .i_pen(pal_pen),
        .o_rgb(pal_rgb), .o_rdata(pal_rdata));

    video_output_stage u_out (.i_EMU_MCLK(i_EMU_MCLK), .i_rst_n(i_rst_n),
        .i_raster(o_raster), .i_obj_pixel(i_obj_pixel), .i_force_black(force_black),
        .i_rgb(pal_rgb), .o_pen(pal_pen), .o_video(o_video));

    //////////////////////////////
    // CPU read mux
    //////////////////////////////

    always_comb
    begin
        o_data_read = `VID_READ_IDLE;       // Pull-up when nobody drives
        if (!i_cpu.rd_n)
        begin
            if (!i_obj_palette_cs_n)
                o_data_read = pal_rdata;    // Latched at last pixel step
            else if (!i_color_ctrl_cs_n)
                o_data_read = ctrl_rdata;
        end
    end

endmodule

//--- source/video_output_stage.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module video_output_stage
(
    input  logic                i_EMU_MCLK,
    input  logic                i_rst_n,
    input  video_pkg::raster_t  i_raster,
    input  video_pkg::pen_t     i_obj_pixel,
    input  logic                i_force_black,
    input  video_pkg::rgb_t     i_rgb,
    output video_pkg::pen_t     o_pen,
    output video_pkg::rgb_t     o_video
);

    logic vis_now;
    logic vis_q0;                           // Travels with o_pen
    logic vis_q1;                           // Travels with the palette latch

    // Opaque pen inside the window
    assign vis_now = i_raster.disp_en &
                     (i_obj_pixel[3:0] != `VID_TRANSPARENT_PEN);

    //////////////////////////////
    // Pen latch, step n
    //////////////////////////////

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (i_raster.pix_cen)
            o_pen <= i_obj_pixel;
    end

    //////////////////////////////
    // Qualifier and RGB latch
    //////////////////////////////

    always_ff @(posedge i_EMU_MCLK or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            vis_q0  <= 1'b0;
            vis_q1  <= 1'b0;
            o_video <= '0;
        end
        else if (i_raster.pix_cen)
        begin
            vis_q0  <= vis_now;
            vis_q1  <= vis_q0;
            o_video <= (vis_q1 & ~i_force_black) ? i_rgb : '0; // Step n+2
        end
    end

endmodule

//--- source/obj_palette_ram.sv
`timescale 1ns/1ps

module obj_palette_ram
(
    input  logic                   i_EMU_MCLK,
    input  logic                   i_cs_n,
    input  video_pkg::cpu_bus_t    i_cpu,
    input  logic                   i_pix_cen,
    input  video_pkg::pen_t        i_pen,
    output video_pkg::rgb_t        o_rgb,
    output video_pkg::cpu_byte_t   o_rdata
);

    // Even bytes hold R:G, odd bytes hold B and a spare nibble
    video_pkg::cpu_byte_t mem_even [256];
    video_pkg::cpu_byte_t mem_odd  [256];

    video_pkg::pen_t      entry;
    logic                 wr_even;
    logic                 wr_odd;
    video_pkg::cpu_byte_t rd_even_q;
    video_pkg::cpu_byte_t rd_odd_q;

    //////////////////////////////
    // Address and strobes
    //////////////////////////////

    // CPU owns the RAM while selected
    assign entry   = i_cs_n ? i_pen : i_cpu.addr[8:1];
    assign wr_even = i_pix_cen & ~i_cs_n & ~i_cpu.wr_n & ~i_cpu.addr[0];
    assign wr_odd  = i_pix_cen & ~i_cs_n & ~i_cpu.wr_n &  i_cpu.addr[0];

    //////////////////////////////
    // Byte arrays
    //////////////////////////////

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (wr_even)
            mem_even[entry] <= i_cpu.wdata;
        if (wr_odd)
            mem_odd[entry] <= i_cpu.wdata;
    end

    // Read latch, shared by pixel lookup and CPU read
    always_ff @(posedge i_EMU_MCLK)
    begin
        if (i_pix_cen)
        begin
            rd_even_q <= mem_even[entry];
            rd_odd_q  <= mem_odd[entry];
        end
    end

    assign o_rgb.r = rd_even_q[7:4];
    assign o_rgb.g = rd_even_q[3:0];
    assign o_rgb.b = rd_odd_q[7:4];         // Low nibble only goes back to CPU

    // Byte select follows the live address bit
    assign o_rdata = i_cpu.addr[0] ? rd_odd_q : rd_even_q;

endmodule

//--- source/color_ctrl_reg.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module color_ctrl_reg
(
    input  logic                   i_EMU_MCLK,
    input  logic                   i_rst_n,
    input  logic                   i_cs_n,
    input  video_pkg::cpu_bus_t    i_cpu,
    input  logic                   i_pix_cen,
    output logic                   o_force_black,
    output video_pkg::cpu_byte_t   o_rdata
);

    video_pkg::cpu_byte_t ctrl_q;
    logic                 wr_en;

    //////////////////////////////
    // Control byte
    //////////////////////////////

    // CPU write lands on the pixel step
    assign wr_en = i_pix_cen & ~i_cs_n & ~i_cpu.wr_n;

    always_ff @(posedge i_EMU_MCLK or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            ctrl_q <= `VID_CTRL_RESET;
        end
        else if (wr_en)
        begin
            ctrl_q <= i_cpu.wdata;          // Full byte kept for read-back
        end
    end

    // Bit 0 low blanks the screen
    assign o_force_black = ~ctrl_q[0];
    assign o_rdata       = ctrl_q;          // Muxed onto the bus at top level

endmodule

//--- source/raster_timing.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module raster_timing
(
    input  logic                i_EMU_MCLK,
    input  logic                i_rst_n,
    input  logic                i_EMU_CLK12MPCEN_n,
    output logic                o_EMU_CLK6MPCEN_n,
    output logic                o_EMU_CLK6MNCEN_n,
    output logic                o_csync,
    output video_pkg::raster_t  o_raster
);

    localparam video_pkg::raster_cnt_t H_FIRST = `VID_H_FIRST;
    localparam video_pkg::raster_cnt_t H_LAST  = `VID_H_LAST;
    localparam video_pkg::raster_cnt_t V_FIRST = `VID_V_FIRST;
    localparam video_pkg::raster_cnt_t V_LAST  = `VID_V_LAST;

    logic [1:0]             cen_div;    // 01 <-> 10 on every 12M step
    logic                   run_q;      // Low through reset, keeps enables idle
    logic                   pix_cen;
    video_pkg::raster_cnt_t hcnt;
    video_pkg::raster_cnt_t vcnt;
    logic                   h_wrap;
    logic                   sync_act;
    logic                   disp_act;
    logic                   disp_en_q;

    //////////////////////////////
    // 6M clock enables
    //////////////////////////////

    always_ff @(posedge i_EMU_MCLK or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            cen_div <= 2'b01;
            run_q   <= 1'b0;
        end
        else
        begin
            run_q <= 1'b1;
            if (!i_EMU_CLK12MPCEN_n)
                cen_div <= ~cen_div;        // Toggle both phases
        end
    end

    // Step and half-step never low together
    assign o_EMU_CLK6MPCEN_n = cen_div[1] | i_EMU_CLK12MPCEN_n | ~run_q;
    assign o_EMU_CLK6MNCEN_n = cen_div[0] | i_EMU_CLK12MPCEN_n | ~run_q;
    assign pix_cen           = ~o_EMU_CLK6MPCEN_n;

    //////////////////////////////
    // Raster counters
    //////////////////////////////

    assign h_wrap = (hcnt == H_LAST);

    always_ff @(posedge i_EMU_MCLK or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            hcnt <= H_FIRST;
            vcnt <= V_FIRST;
        end
        else if (pix_cen)
        begin
            hcnt <= h_wrap ? H_FIRST : hcnt + 9'd1;
            if (h_wrap)                     // New line
                vcnt <= (vcnt == V_LAST) ? V_FIRST : vcnt + 9'd1;
        end
    end

    //////////////////////////////
    // Sync and window
    //////////////////////////////

    // Decoded from the counts before the step
    assign sync_act = (hcnt >= `VID_HSYNC_FIRST && hcnt <= `VID_HSYNC_LAST) ||
                      (vcnt >= `VID_VSYNC_FIRST && vcnt <= `VID_VSYNC_LAST);
    assign disp_act = (hcnt >= `VID_HDISP_FIRST) &&
                      (vcnt >= `VID_VDISP_FIRST && vcnt <= `VID_VDISP_LAST);

    always_ff @(posedge i_EMU_MCLK or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_csync   <= 1'b1;
            disp_en_q <= 1'b0;
        end
        else if (pix_cen)
        begin
            o_csync   <= ~sync_act;         // Composite, active low
            disp_en_q <= disp_act;
        end
    end

    assign o_raster.hcnt    = hcnt;
    assign o_raster.vcnt    = vcnt;
    assign o_raster.pix_cen = pix_cen;
    assign o_raster.disp_en = disp_en_q;

endmodule

//--- source/video_pkg.sv
package video_pkg;

    //////////////////////////////
    // Plain widths
    //////////////////////////////

    typedef logic [8:0] raster_cnt_t;   // H or V count
    typedef logic [7:0] pen_t;          // Sprite palette index
    typedef logic [3:0] color4_t;       // One channel
    typedef logic [7:0] cpu_byte_t;
    typedef logic [8:0] cpu_addr_t;     // [8:1] entry, [0] byte select

    //////////////////////////////
    // Bundles
    //////////////////////////////

    typedef struct packed {
        color4_t r;
        color4_t g;
        color4_t b;
    } rgb_t;                            // 12 bits

    // Raster state shared by every block downstream of the counters
    typedef struct packed {
        raster_cnt_t hcnt;
        raster_cnt_t vcnt;
        logic        pix_cen;           // Active-high pixel step
        logic        disp_en;           // Visible area, one step late
    } raster_t;                         // 20 bits

    typedef struct packed {
        cpu_addr_t   addr;
        cpu_byte_t   wdata;
        logic        rd_n;
        logic        wr_n;
    } cpu_bus_t;                        // 19 bits

endpackage

//--- include/video_cfg.svh
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

//////////////////////////////
// Raster limits
//////////////////////////////

`define VID_H_FIRST          128    // 384 pixels per line
`define VID_H_LAST           511
`define VID_V_FIRST          248    // 264 lines per frame
`define VID_V_LAST           511

// Sync and visible window, in raw counter values
`define VID_HSYNC_FIRST      176
`define VID_HSYNC_LAST       207
`define VID_VSYNC_FIRST      496
`define VID_VSYNC_LAST       503
`define VID_HDISP_FIRST      256    // Visible up to H_LAST
`define VID_VDISP_FIRST      272
`define VID_VDISP_LAST       495

//////////////////////////////
// Pixel and register values
//////////////////////////////

`define VID_TRANSPARENT_PEN  4'hF   // Low nibble of a see-through sprite pen
`define VID_CTRL_RESET       8'h01  // Force-black released
`define VID_READ_IDLE        8'hFF  // Bus pull-up level

`endif
